//--- include/rename_cfg.svh
// Rename core configuration
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

////////////////////
// Register counts
////////////////////

`define ARCH_REGS  8    // Architectural registers
`define PHYS_REGS  16   // Physical registers, ARCH_REGS of them mapped at reset

////////////////////
// Queue depths
////////////////////

`define ROB_DEPTH  8    // Reorder buffer entries
`define IBUF_DEPTH 4    // Instruction buffer entries

`endif

//--- src/rename_pkg.sv
// Rename core types
`default_nettype none

`include "rename_cfg.svh"

package rename_pkg;

    // Index types, sized from the register counts and ROB depth
    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_idx_t;
    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_reg_idx_t;
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

    // Instruction as held in the instruction buffer
    typedef struct packed {
        logic          has_dest;    // Writes a register
        arch_reg_idx_t dest_arch;   // Destination arch register
    } inst_entry_t;

    // Reorder buffer entry
    // old_phys is what dest_arch mapped to before this instruction,
    // freed once the entry retires
    typedef struct packed {
        logic          has_dest;
        arch_reg_idx_t dest_arch;
        phys_reg_idx_t new_phys;    // Tag the instruction completes on
        phys_reg_idx_t old_phys;    // Released at retire
    } rob_entry_t;

endpackage

`default_nettype wire

//--- src/circ_queue.sv
// Circular FIFO
`default_nettype none

module circ_queue #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic
) (
    input  wire logic                     clock,
    input  wire logic                     arst_n,

    // Push side
    input  wire logic                     push_valid,
    output logic                          push_ready,   // Not full
    input  wire payload_t                 push_data,

    // Pop side
    output logic                          pop_valid,    // Not empty
    input  wire logic                     pop_ready,
    output payload_t                      pop_data,     // Head slot, combinational

    output logic [$clog2(DEPTH)-1:0]      head_idx,     // Slot of the oldest entry
    output logic [$clog2(DEPTH)-1:0]      tail_idx      // Slot the next push lands in
);

    localparam int IDX_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];  // Storage, no reset
    logic [IDX_W-1:0] head;
    logic [IDX_W-1:0] tail;
    logic [CNT_W-1:0] count;        // Entries held
    logic             do_push;
    logic             do_pop;

    // Wrap a pointer at DEPTH, depth need not be a power of two
    function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
        next_idx = (idx == IDX_W'(DEPTH - 1)) ? '0 : idx + 1'b1;
    endfunction

    ////////////////////
    // Status
    ////////////////////

    assign push_ready = (count != CNT_W'(DEPTH));
    assign pop_valid  = (count != '0);
    assign do_push    = push_valid & push_ready;
    assign do_pop     = pop_valid & pop_ready;

    assign pop_data   = mem[head];  // Pop is seen in the same cycle
    assign head_idx   = head;
    assign tail_idx   = tail;

    ////////////////////
    // Pointers
    ////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_push) tail <= next_idx(tail);
            if (do_pop)  head <= next_idx(head);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase
        end
    end

    // Written entry reaches the head one cycle later at the earliest
    always_ff @(posedge clock) begin
        if (do_push) mem[tail] <= push_data;
    end

endmodule

`default_nettype wire

//--- src/map_table.sv
// Architectural to physical map
`default_nettype none

`include "rename_cfg.svh"

module map_table (
    input  wire logic                    clock,
    input  wire logic                    arst_n,

    input  wire rename_pkg::arch_reg_idx_t read_arch,   // Also the write address
    output rename_pkg::phys_reg_idx_t      read_phys,   // Current mapping, combinational

    input  wire logic                    write_en,
    input  wire rename_pkg::phys_reg_idx_t write_phys
);

    import rename_pkg::*;

    phys_reg_idx_t map [`ARCH_REGS];    // Speculative map

    // Old mapping goes out the same cycle the new one is written
    assign read_phys = map[read_arch];

    // Identity map out of reset, arch r lives in phys r
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map[i] <= phys_reg_idx_t'(i);
            end
        end else if (write_en) begin
            map[read_arch] <= write_phys;   // Rename the destination
        end
    end

endmodule

`default_nettype wire

//--- src/phys_reg_status.sv
// Physical register free and complete lists
`default_nettype none

`include "rename_cfg.svh"

module phys_reg_status (
    input  wire logic                      clock,
    input  wire logic                      arst_n,

    // Allocation at dispatch
    input  wire logic                      alloc_en,
    output rename_pkg::phys_reg_idx_t      alloc_phys,    // Lowest free register
    output logic                           alloc_avail,   // Any register free

    // Completion from the CDB
    input  wire logic                      complete_en,
    input  wire rename_pkg::phys_reg_idx_t complete_phys,

    // Release at retire
    input  wire logic                      release_en,
    input  wire rename_pkg::phys_reg_idx_t release_phys,

    output logic [`PHYS_REGS-1:0]          complete_list
);

    import rename_pkg::*;

    logic [`PHYS_REGS-1:0] free_vec;
    logic [`PHYS_REGS-1:0] free_next;
    logic [`PHYS_REGS-1:0] complete_next;

    // Priority encoder, lowest index wins
    always_comb begin
        alloc_phys = '0;
        for (int i = `PHYS_REGS - 1; i >= 0; i--) begin
            if (free_vec[i]) alloc_phys = phys_reg_idx_t'(i);
        end
    end

    assign alloc_avail = |free_vec;

    ////////////////////
    // Next state
    ////////////////////

    always_comb begin
        free_next     = free_vec;
        complete_next = complete_list;
        if (alloc_en) begin
            free_next[alloc_phys]     = 1'b0;
            complete_next[alloc_phys] = 1'b0;   // New value not produced yet
        end
        // Tag not in flight is dropped
        if (complete_en && !free_vec[complete_phys]) complete_next[complete_phys] = 1'b1;
        if (release_en) free_next[release_phys] = 1'b1;  // Allocatable next cycle
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `PHYS_REGS; i++) begin
                free_vec[i] <= (i >= `ARCH_REGS);   // Upper registers start free
            end
            complete_list <= '1;                    // Mapped registers hold committed values
        end else begin
            free_vec      <= free_next;
            complete_list <= complete_next;
        end
    end

endmodule

`default_nettype wire

//--- src/dispatch.sv
// Dispatch stage
`default_nettype none

module dispatch (
    // Instruction buffer head
    input  wire logic                      ibuf_valid,
    input  wire rename_pkg::inst_entry_t   ibuf_data,
    output logic                           ibuf_ready,

    input  wire logic                      rob_ready,     // ROB not full

    // Free list and map
    input  wire logic                      alloc_avail,
    input  wire rename_pkg::phys_reg_idx_t alloc_phys,
    input  wire rename_pkg::phys_reg_idx_t old_phys,      // Current mapping of dest
    output logic                           alloc_en,
    output logic                           map_write_en,

    // ROB push
    output logic                           rob_valid,
    output rename_pkg::rob_entry_t         rob_data
);

    logic reg_ok;   // Register side can accept
    logic fire;     // Head leaves the buffer this cycle

    // Stall on a full ROB, or on a destination with no free register
    assign reg_ok     = !ibuf_data.has_dest || alloc_avail;
    assign ibuf_ready = rob_ready & reg_ok;
    assign rob_valid  = ibuf_valid & reg_ok;
    assign fire       = ibuf_valid & ibuf_ready;

    // Only instructions with a destination touch the free list and map
    assign alloc_en     = fire & ibuf_data.has_dest;
    assign map_write_en = fire & ibuf_data.has_dest;

    ////////////////////
    // ROB entry
    ////////////////////

    always_comb begin
        rob_data = '0;                              // No destination, no registers
        if (ibuf_data.has_dest) begin
            rob_data.has_dest  = 1'b1;
            rob_data.dest_arch = ibuf_data.dest_arch;
            rob_data.new_phys  = alloc_phys;
            rob_data.old_phys  = old_phys;          // Freed when this entry retires
        end
    end

endmodule

`default_nettype wire

//--- src/retire.sv
// In-order retire
`default_nettype none

`include "rename_cfg.svh"

module retire (
    input  wire logic                      clock,
    input  wire logic                      arst_n,

    // ROB head
    input  wire logic                      rob_valid,
    input  wire rename_pkg::rob_entry_t    rob_data,
    output logic                           rob_ready,

    input  wire logic [`PHYS_REGS-1:0]     complete_list,

    // Free list release
    output logic                           release_en,
    output rename_pkg::phys_reg_idx_t      release_phys,

    // Commit report, one edge after the pop
    output logic                           commit_valid,
    output rename_pkg::arch_reg_idx_t      commit_arch_reg,
    output rename_pkg::phys_reg_idx_t      commit_phys_reg,
    output rename_pkg::phys_reg_idx_t      commit_old_phys_reg
);

    logic retiring;

    // Head may go once its value exists, or at once with no destination
    assign rob_ready = !rob_data.has_dest || complete_list[rob_data.new_phys];
    assign retiring  = rob_valid & rob_ready;

    assign release_en   = retiring & rob_data.has_dest;
    assign release_phys = rob_data.old_phys;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) commit_valid <= 1'b0;
        else         commit_valid <= retiring;
    end

    // Report payload
    always_ff @(posedge clock) begin
        if (retiring) begin
            commit_arch_reg     <= rob_data.dest_arch;
            commit_phys_reg     <= rob_data.new_phys;
            commit_old_phys_reg <= rob_data.old_phys;
        end
    end

endmodule

`default_nettype wire

//--- src/rename_core.sv
// Register rename core
`default_nettype none

`include "rename_cfg.svh"

module rename_core (
    input  wire logic                       clock,
    input  wire logic                       arst_n,

    // Instruction input
    input  wire logic                       inst_valid,
    input  wire logic                       inst_has_dest,
    input  wire rename_pkg::arch_reg_idx_t  inst_dest_arch,
    output logic                            inst_ready,

    // Dispatch report
    output logic                            dispatch_valid,
    output rename_pkg::rob_idx_t            dispatch_rob_idx,
    output rename_pkg::phys_reg_idx_t       dispatch_phys_reg,

    // Completion, stands in for the CDB
    input  wire logic                       cdb_valid,
    input  wire rename_pkg::phys_reg_idx_t  cdb_tag,

    // Commit report
    output logic                            commit_valid,
    output rename_pkg::arch_reg_idx_t       commit_arch_reg,
    output rename_pkg::phys_reg_idx_t       commit_phys_reg,
    output rename_pkg::phys_reg_idx_t       commit_old_phys_reg
);

    import rename_pkg::*;

    inst_entry_t           ibuf_push_data;
    logic                  ibuf_pop_valid, ibuf_pop_ready;
    inst_entry_t           ibuf_pop_data;
    logic                  rob_push_valid, rob_push_ready;
    rob_entry_t            rob_push_data;
    logic                  rob_pop_valid, rob_pop_ready;
    rob_entry_t            rob_pop_data;
    phys_reg_idx_t         alloc_phys, old_phys, release_phys;
    logic                  alloc_en, alloc_avail, map_write_en, release_en;
    logic [`PHYS_REGS-1:0] complete_list;

    assign ibuf_push_data    = '{has_dest: inst_has_dest, dest_arch: inst_dest_arch};
    assign dispatch_valid    = ibuf_pop_valid & ibuf_pop_ready;    // Head dispatches this cycle
    assign dispatch_phys_reg = rob_push_data.new_phys;

    ////////////////////
    // Queues
    ////////////////////

    circ_queue #(.DEPTH(`IBUF_DEPTH), .payload_t(inst_entry_t)) i_ibuf (
        .clock, .arst_n,
        .push_valid (inst_valid),     .push_ready (inst_ready),     .push_data (ibuf_push_data),
        .pop_valid  (ibuf_pop_valid), .pop_ready  (ibuf_pop_ready), .pop_data  (ibuf_pop_data),
        .head_idx   (),               .tail_idx   ()                // Slots not needed outside
    );

    circ_queue #(.DEPTH(`ROB_DEPTH), .payload_t(rob_entry_t)) i_rob (
        .clock, .arst_n,
        .push_valid (rob_push_valid), .push_ready (rob_push_ready), .push_data (rob_push_data),
        .pop_valid  (rob_pop_valid),  .pop_ready  (rob_pop_ready),  .pop_data  (rob_pop_data),
        .head_idx   (),               .tail_idx   (dispatch_rob_idx)   // Slot being written
    );

    ////////////////////
    // Rename state
    ////////////////////

    map_table i_map_table (
        .clock, .arst_n,
        .read_arch (ibuf_pop_data.dest_arch), .read_phys (old_phys),
        .write_en  (map_write_en),            .write_phys (alloc_phys)
    );

    phys_reg_status i_phys_reg_status (
        .clock, .arst_n,
        .alloc_en, .alloc_phys, .alloc_avail,
        .complete_en (cdb_valid), .complete_phys (cdb_tag),        // CDB goes straight in
        .release_en, .release_phys, .complete_list
    );

    ////////////////////
    // Dispatch, retire
    ////////////////////

    dispatch i_dispatch (
        .ibuf_valid (ibuf_pop_valid), .ibuf_data (ibuf_pop_data), .ibuf_ready (ibuf_pop_ready),
        .rob_ready  (rob_push_ready), .alloc_avail, .alloc_phys, .old_phys,
        .alloc_en,  .map_write_en,    .rob_valid (rob_push_valid), .rob_data (rob_push_data)
    );

    retire i_retire (
        .clock, .arst_n,
        .rob_valid (rob_pop_valid), .rob_data (rob_pop_data), .rob_ready (rob_pop_ready),
        .complete_list, .release_en, .release_phys,
        .commit_valid, .commit_arch_reg, .commit_phys_reg, .commit_old_phys_reg
    );

endmodule

`default_nettype wire

//--- verification/rename_core_chk.sv
// Rename core assertions
`default_nettype none

`include "rename_cfg.svh"

module rename_core_chk (
    input  wire logic                      clock,
    input  wire logic                      arst_n,

    // Instruction buffer traffic
    input  wire logic                      inst_valid,
    input  wire logic                      inst_ready,
    input  wire logic                      dispatch_valid,

    // Dispatch side
    input  wire rename_pkg::rob_entry_t    rob_push_data,
    input  wire rename_pkg::phys_reg_idx_t dispatch_phys_reg,

    // Completion and retire side
    input  wire logic                      cdb_valid,
    input  wire rename_pkg::phys_reg_idx_t cdb_tag,
    input  wire logic                      rob_pop_valid,
    input  wire logic                      rob_pop_ready,
    input  wire rename_pkg::rob_entry_t    rob_pop_data,
    input  wire logic                      release_en,
    input  wire rename_pkg::phys_reg_idx_t release_phys,
    input  wire logic                      commit_valid
);

    import rename_pkg::*;

    int                    fail_count = 0;  // Read by the testbench
    int                    ibuf_cnt;        // Shadow of buffer occupancy
    logic [`PHYS_REGS-1:0] busy;            // Mapped or in flight
    logic [`PHYS_REGS-1:0] done;            // Value produced

    ////////////////////
    // Shadow state
    ////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ibuf_cnt <= 0;
            for (int i = 0; i < `PHYS_REGS; i++) begin
                busy[i] <= (i < `ARCH_REGS);    // Identity map holds the low registers
            end
            done <= '1;
        end else begin
            ibuf_cnt <= ibuf_cnt + int'(inst_valid && inst_ready) - int'(dispatch_valid);
            if (cdb_valid && busy[cdb_tag]) done[cdb_tag] <= 1'b1;
            if (release_en) busy[release_phys] <= 1'b0;
            if (dispatch_valid && rob_push_data.has_dest) begin
                busy[dispatch_phys_reg] <= 1'b1;    // Fresh tag, value pending
                done[dispatch_phys_reg] <= 1'b0;
            end
        end
    end

    ////////////////////
    // Assertions
    ////////////////////

    // Tag handed out must be idle
    a_alloc_idle: assert property (@(posedge clock) disable iff (!arst_n)
        dispatch_valid && rob_push_data.has_dest |-> !busy[dispatch_phys_reg])
        else begin $error("Dispatch of a register still in use"); fail_count++; end

    // Retire only once the value exists
    a_retire_done: assert property (@(posedge clock) disable iff (!arst_n)
        rob_pop_valid && rob_pop_ready |-> !rob_pop_data.has_dest || done[rob_pop_data.new_phys])
        else begin $error("Retire of an incomplete entry"); fail_count++; end

    a_ibuf_full: assert property (@(posedge clock) disable iff (!arst_n)
        inst_ready == (ibuf_cnt != `IBUF_DEPTH))    // Full exactly at depth
        else begin $error("inst_ready disagrees with buffer occupancy"); fail_count++; end

    // Commit follows its pop by one edge, never while in reset
    a_commit_after_pop: assert property (@(posedge clock)
        commit_valid |-> $past(arst_n && rob_pop_valid && rob_pop_ready))
        else begin $error("Commit without a retire one edge earlier"); fail_count++; end

endmodule

bind rename_core rename_core_chk i_chk (
    .clock, .arst_n, .inst_valid, .inst_ready, .dispatch_valid,
    .rob_push_data, .dispatch_phys_reg, .cdb_valid, .cdb_tag,
    .rob_pop_valid, .rob_pop_ready, .rob_pop_data, .release_en, .release_phys,
    .commit_valid
);

`default_nettype wire

//--- verification/rename_core_tb.sv
// Rename core testbench
`default_nettype none

`include "rename_cfg.svh"

module rename_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import rename_pkg::*;

    localparam int NUM_TESTS  = 6;
    localparam int TIMEOUT_NS = NUM_TESTS * 200 * 8;    // 200 cycles per test

    logic          clock = 1'b0;
    logic          arst_n = 1'b0;
    logic          inst_valid = 1'b0;
    logic          inst_has_dest = 1'b0;
    arch_reg_idx_t inst_dest_arch = '0;
    logic          cdb_valid = 1'b0;
    phys_reg_idx_t cdb_tag = '0;
    logic          inst_ready, dispatch_valid, commit_valid;
    rob_idx_t      dispatch_rob_idx;
    phys_reg_idx_t dispatch_phys_reg, commit_phys_reg, commit_old_phys_reg;
    arch_reg_idx_t commit_arch_reg;

    // Reference model
    logic [`PHYS_REGS-1:0] free_m;
    logic [`PHYS_REGS-1:0] was_freed;   // Released during the current test
    phys_reg_idx_t         map_m [`ARCH_REGS];
    rob_idx_t              rob_tail_m;      // ROB slot the next dispatch takes
    inst_entry_t           accepted [$];    // Accepted, not yet dispatched
    rob_entry_t            expq [$];        // Expected commits, oldest first
    phys_reg_idx_t         pool [$];        // Dispatched, not yet completed
    logic                  cdb_on = 1'b0;

    string cur_test;
    int    errors, test_errors, tests_failed, chk_base;
    int    dest_dispatches, commits, reuses;

    rename_core i_dut (.*);

    initial begin
        forever #4 clock = ~clock;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

    function automatic int lowest_free(input logic [`PHYS_REGS-1:0] v);
        for (int i = 0; i < `PHYS_REGS; i++) begin
            if (v[i]) return i;
        end
        return -1;
    endfunction

    task automatic check(input string what, input int exp, input int act);
        if (exp != act) begin
            $display("Fail %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    ////////////////////
    // Monitor and model
    ////////////////////

    always @(posedge clock) begin
        rob_entry_t  e;
        inst_entry_t ins;
        int          p;
        if (!arst_n) begin
            for (int i = 0; i < `PHYS_REGS; i++) free_m[i] = (i >= `ARCH_REGS);
            for (int i = 0; i < `ARCH_REGS; i++) map_m[i] = phys_reg_idx_t'(i);
            was_freed  = '0;
            rob_tail_m = '0;
            cdb_valid <= 1'b0;
        end else begin
            if (inst_valid && inst_ready) begin
                accepted.push_back(inst_entry_t'{inst_has_dest, inst_dest_arch});
            end
            // Commits first, a release can feed this edge's dispatch
            if (commit_valid) begin
                commits++;
                if (expq.size() == 0) begin
                    $display("Commit reported with nothing outstanding in %s", cur_test);
                    errors++;
                    test_errors++;
                end else begin
                    e = expq.pop_front();
                    check("commit arch", e.dest_arch, commit_arch_reg);
                    check("commit phys", e.new_phys, commit_phys_reg);
                    check("commit old phys", e.old_phys, commit_old_phys_reg);
                    if (e.has_dest) begin
                        free_m[e.old_phys]    = 1'b1;
                        was_freed[e.old_phys] = 1'b1;
                    end
                end
            end
            if (dispatch_valid) begin
                ins = accepted.pop_front();
                check("dispatch rob slot", rob_tail_m, dispatch_rob_idx);
                rob_tail_m = rob_idx_t'((int'(rob_tail_m) + 1) % `ROB_DEPTH);  // Slots in order
                e   = '0;   // No destination records no registers
                if (ins.has_dest) begin
                    dest_dispatches++;
                    p = lowest_free(free_m);
                    check("dispatch phys", p, dispatch_phys_reg);
                    if (was_freed[dispatch_phys_reg]) reuses++;   // Released one back in use
                    e = '{1'b1, ins.dest_arch, phys_reg_idx_t'(p), map_m[ins.dest_arch]};
                    free_m[p]            = 1'b0;
                    map_m[ins.dest_arch] = phys_reg_idx_t'(p);
                    pool.push_back(phys_reg_idx_t'(p));
                end
                expq.push_back(e);
            end
            // Random completion order from the in-flight pool
            if (cdb_on && pool.size() > 0 && $urandom_range(1, 0) == 1) begin
                p = $urandom_range(pool.size() - 1, 0);
                cdb_valid <= 1'b1;
                cdb_tag   <= pool[p];
                pool.delete(p);
            end else begin
                cdb_valid <= 1'b0;
            end
        end
    end

    ////////////////////
    // Stimulus tasks
    ////////////////////

    task automatic send(input logic has, input arch_reg_idx_t arch);
        @(posedge clock);
        inst_valid     <= 1'b1;
        inst_has_dest  <= has;
        inst_dest_arch <= arch;
        do @(posedge clock); while (!inst_ready);   // Wait for the handshake
        inst_valid <= 1'b0;
    endtask

    task automatic drain();
        while (expq.size() != 0 || accepted.size() != 0 || inst_valid) @(posedge clock);
        @(posedge clock);
    endtask

    task automatic begin_test(input string name);
        cur_test        = name;
        test_errors     = 0;
        chk_base        = i_dut.i_chk.fail_count;
        was_freed       = '0;
        dest_dispatches = 0;
        commits         = 0;
        reuses          = 0;
    endtask

    task automatic end_test();
        int n;
        n = test_errors + i_dut.i_chk.fail_count - chk_base;
        if (n != 0) tests_failed++;
        $display("Test %s finished with %0d errors", cur_test, n);
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        int sent;
        void'($urandom(32'he881_369e));
        repeat (4) @(posedge clock);
        arst_n <= 1'b1;

        begin_test("reset_state");
        repeat (5) begin
            @(posedge clock);
            check("inst_ready", 1, inst_ready);
            check("dispatch_valid", 0, dispatch_valid);
            check("commit_valid", 0, commit_valid);
        end
        end_test();

        begin_test("renaming");
        cdb_on = 1'b1;
        for (int i = 0; i < 6; i++) send(1'b1, arch_reg_idx_t'($urandom_range(7, 0)));
        drain();
        check("commits", 6, commits);
        end_test();

        begin_test("in_order_retire");
        cdb_on = 1'b0;  // Hold completions until all are in flight
        for (int i = 0; i < 6; i++) send(1'b1, arch_reg_idx_t'($urandom_range(7, 0)));
        while (accepted.size() != 0) @(posedge clock);
        cdb_on = 1'b1;
        drain();
        check("commits", 6, commits);
        end_test();

        begin_test("back_pressure");
        cdb_on = 1'b0;
        sent   = 14;
        fork
            for (int i = 0; i < 14; i++) send(1'b1, arch_reg_idx_t'(i % `ARCH_REGS));
        join_none
        @(posedge clock);
        while (inst_ready) @(posedge clock);
        repeat (4) @(posedge clock);
        check("dispatches while stalled", 8, dest_dispatches);
        check("inst_ready while stalled", 0, inst_ready);
        cdb_on = 1'b1;
        wait fork;
        drain();
        check("commits", sent, commits);
        end_test();

        begin_test("register_recycling");
        for (int i = 0; i < 16; i++) send(1'b1, arch_reg_idx_t'(i % `ARCH_REGS));
        drain();
        check("released register handed out again", 1, int'(reuses > 0));
        end_test();

        begin_test("no_destination");
        cdb_on = 1'b0;  // Must commit with no completions at all
        for (int i = 0; i < 4; i++) send(1'b0, arch_reg_idx_t'(i));
        drain();
        check("commits", 4, commits);
        // Free list untouched, so the next destination gets the model's lowest free
        cdb_on = 1'b1;
        send(1'b1, arch_reg_idx_t'(0));
        drain();
        check("commits", 5, commits);
        end_test();

        $display("%0d tests, %0d failed, %0d value errors, %0d assertion failures",
                 NUM_TESTS, tests_failed, errors, i_dut.i_chk.fail_count);
        if (tests_failed == 0 && errors == 0 && i_dut.i_chk.fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
src/rename_pkg.sv
src/circ_queue.sv
src/map_table.sv
src/phys_reg_status.sv
src/dispatch.sv
src/retire.sv
src/rename_core.sv
verification/rename_core_chk.sv
verification/rename_core_tb.sv

//--- Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
TOP        = rename_core_tb
FILELIST   = vlog.f
RUN_ARGS   = +verilator+error+limit+1000
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)

run: build
	./obj_dir/$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
